// File: bench/tb_rv_decode.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module tb_rv_decode;

    localparam int NUM_CYCLES      = 900;
    localparam int NUM_DIRECTED    = 10;
    localparam int WATCHDOG_CYCLES = 2000;

    logic              i_clk;
    logic              i_rst;
    logic              i_stall;
    logic              i_flush;
    rv_pkg::instr_t    i_data;
    rv_pkg::pc_t       i_pc;
    rv_pkg::pc_t       i_pc_p4;
    rv_pkg::reg_idx_t  o_rs1;
    rv_pkg::reg_idx_t  o_rs2;
    rv_pkg::reg_idx_t  o_rd;
    logic [2:0]        o_funct3;
    rv_pkg::pc_t       o_pc;
    rv_pkg::pc_t       o_pc_p4;
    rv_pkg::imm_t      o_imm;
    logic              o_reg_write;
    logic              o_mem_read;
    logic              o_mem_write;
    logic              o_jump;
    logic              o_branch;
    logic              o_pc_sel;
    logic              o_alu_op1_sel;
    logic              o_alu_op2_sel;
    rv_pkg::res_src_t  o_res_src;
    rv_pkg::alu_ctrl_t o_alu_ctrl;
    logic              o_inv_instr;

    int                errors;
    int                stall_left;
    logic [31:0]       rng;
    logic [31:0]       a;
    logic [31:0]       b;
    logic [31:0]       p;

    // reference state for the word under decode
    logic              model_stalled;
    logic              model_flushed;
    rv_pkg::instr_t    model_held;
    rv_pkg::pc_t       model_pc;
    rv_pkg::pc_t       model_pc_p4;
    logic              pc_valid;
    rv_pkg::instr_t    exp_word;
    rv_pkg::reg_idx_t  exp_rs1;
    logic [14:0]       exp_ctrl;
    logic [14:0]       dut_ctrl;

    rv_decode i_dut
    (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_stall       (i_stall),
        .i_flush       (i_flush),
        .i_data        (i_data),
        .i_pc          (i_pc),
        .i_pc_p4       (i_pc_p4),
        .o_rs1         (o_rs1),
        .o_rs2         (o_rs2),
        .o_rd          (o_rd),
        .o_funct3      (o_funct3),
        .o_pc          (o_pc),
        .o_pc_p4       (o_pc_p4),
        .o_imm         (o_imm),
        .o_reg_write   (o_reg_write),
        .o_mem_read    (o_mem_read),
        .o_mem_write   (o_mem_write),
        .o_jump        (o_jump),
        .o_branch      (o_branch),
        .o_pc_sel      (o_pc_sel),
        .o_alu_op1_sel (o_alu_op1_sel),
        .o_alu_op2_sel (o_alu_op2_sel),
        .o_res_src     (o_res_src),
        .o_alu_ctrl    (o_alu_ctrl),
        .o_inv_instr   (o_inv_instr)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic is_invalid(input logic [31:0] w);
        logic [2:0] f3;
        logic [6:0] f7;
        f3 = w[14:12];
        f7 = w[31:25];
        if (w == '0)
            return 1'b0;
        if (w[1:0] != 2'b11)
            return 1'b1;
        case (w[6:2])
        `RV_OP_LOAD:      return !(f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5});
        `RV_OP_MISC_MEM:  return f3 > 3'd1;
        `RV_OP_ARITH_IMM: return (f3 == 3'd1 && f7 != `RV_FUNCT7_BASE)
                                 || (f3 == 3'd5 && !(f7 inside {`RV_FUNCT7_BASE, `RV_FUNCT7_ALT}));
        `RV_OP_STORE:     return f3 > 3'd2;
        `RV_OP_ARITH_REG: return !(f7 == `RV_FUNCT7_BASE
                                   || (f7 == `RV_FUNCT7_ALT && (f3 == 3'd0 || f3 == 3'd5)));
        `RV_OP_BRANCH:    return f3 inside {3'd2, 3'd3};
        `RV_OP_JALR:      return f3 != 3'd0;
        `RV_OP_AUIPC, `RV_OP_LUI, `RV_OP_JAL:
            return 1'b0;
        default:          return 1'b1;
        endcase
    endfunction

    function automatic logic [31:0] imm_for_word(input logic [31:0] w);
        logic [31:0] s;
        s = {32{w[31]}};
        if (w == '0 || is_invalid(w))
            return '0;
        case (w[6:2])
        `RV_OP_LOAD, `RV_OP_ARITH_IMM, `RV_OP_JALR:
            return {s[31:12], w[31:20]};
        `RV_OP_STORE:
            return {s[31:12], w[31:25], w[11:7]};
        `RV_OP_BRANCH:
            return {s[31:13], w[31], w[7], w[30:25], w[11:8], 1'b0};
        `RV_OP_LUI, `RV_OP_AUIPC:
            return {w[31:12], 12'h000};
        `RV_OP_JAL:
            return {s[31:21], w[31], w[19:12], w[20], w[30:21], 1'b0};
        default:
            return '0;
        endcase
    endfunction

    // {reg_write, mem_read, mem_write, jump, branch, pc_sel, op1, op2, res_src, alu_ctrl}
    function automatic logic [14:0] controls_for_word(input logic [31:0] w);
        logic       ok;
        logic [4:0] grp;
        logic       jmp;
        logic [1:0] res;
        logic [4:0] alu;
        ok  = (w != '0) && !is_invalid(w);
        grp = w[6:2];
        jmp = ok && (grp inside {`RV_OP_JAL, `RV_OP_JALR});
        res = `RESULT_SRC_ALU;
        if (ok && grp == `RV_OP_LOAD)
            res = `RESULT_SRC_MEMORY;
        else if (jmp)
            res = `RESULT_SRC_PC_P4;
        alu = {1'b0, `ALU_CTRL_ADD};
        if (ok && (grp inside {`RV_OP_ARITH_IMM, `RV_OP_ARITH_REG}))
        begin
            case (w[14:12])
            // bit 5 of the opcode tells register from immediate form
            3'd0:    alu[3:0] = (w[5] && w[30]) ? `ALU_CTRL_SUB : `ALU_CTRL_ADD;
            3'd1:    alu[3:0] = `ALU_CTRL_SHL;
            3'd2:    alu[3:0] = `ALU_CMP_LTS;
            3'd3:    alu[3:0] = `ALU_CMP_LTU;
            3'd4:    alu[3:0] = `ALU_CTRL_XOR;
            3'd5:    alu = {w[30], `ALU_CTRL_SHR};
            3'd6:    alu[3:0] = `ALU_CTRL_OR;
            default: alu[3:0] = `ALU_CTRL_AND;
            endcase
        end
        if (ok && grp == `RV_OP_BRANCH)
        begin
            case (w[14:12])
            3'd0:    alu[3:0] = `ALU_CMP_EQ;
            3'd1:    alu[3:0] = `ALU_CMP_NEQ;
            3'd4:    alu[3:0] = `ALU_CMP_LTS;
            3'd5:    alu[3:0] = `ALU_CMP_NLTS;
            3'd6:    alu[3:0] = `ALU_CMP_LTU;
            default: alu[3:0] = `ALU_CMP_NLTU;
            endcase
        end
        return {ok && (grp inside {`RV_OP_LOAD, `RV_OP_ARITH_IMM, `RV_OP_ARITH_REG,
                                   `RV_OP_LUI, `RV_OP_AUIPC, `RV_OP_JAL, `RV_OP_JALR}),
                ok && grp == `RV_OP_LOAD,
                ok && grp == `RV_OP_STORE,
                jmp,
                ok && grp == `RV_OP_BRANCH,
                ok && grp == `RV_OP_JALR,
                (ok && (grp inside {`RV_OP_AUIPC, `RV_OP_JAL})) ? `ALU_SRC_OP1_PC
                                                               : `ALU_SRC_OP1_REG,
                (ok && (grp inside {`RV_OP_LOAD, `RV_OP_STORE, `RV_OP_ARITH_IMM, `RV_OP_LUI,
                                    `RV_OP_AUIPC, `RV_OP_JAL, `RV_OP_JALR}))
                    ? `ALU_SRC_OP2_IMM : `ALU_SRC_OP2_REG,
                res,
                alu};
    endfunction

    // mostly kept opcodes, with system words and broken low bits mixed in
    function automatic logic [31:0] random_word(input logic [31:0] x, input logic [31:0] y);
        logic [4:0]  grp;
        logic [31:0] w;
        grp = `RV_OP_LOAD;
        case (y[3:0])
        4'd0, 4'd1: grp = `RV_OP_ARITH_IMM;
        4'd2, 4'd3: grp = `RV_OP_ARITH_REG;
        4'd4:       grp = `RV_OP_LOAD;
        4'd5:       grp = `RV_OP_STORE;
        4'd6:       grp = `RV_OP_BRANCH;
        4'd7:       grp = `RV_OP_LUI;
        4'd8:       grp = `RV_OP_AUIPC;
        4'd9:       grp = `RV_OP_JAL;
        4'd10:      grp = `RV_OP_JALR;
        4'd11:      grp = `RV_OP_MISC_MEM;
        4'd12:      grp = `RV_OP_SYSTEM;
        4'd13:      return {x[31:2], y[4] ? 2'b10 : 2'b01};
        default:    return x;
        endcase
        w = {x[31:7], grp, 2'b11};
        if (y[6:4] != 3'd0 && (grp == `RV_OP_ARITH_REG
                               || (grp == `RV_OP_ARITH_IMM && w[13:12] == 2'b01)))
            w[31:25] = y[7] ? `RV_FUNCT7_ALT : `RV_FUNCT7_BASE;
        if (grp == `RV_OP_JALR && y[8])
            w[14:12] = 3'd0;
        return w;
    endfunction

    function automatic logic [31:0] directed_word(input int idx);
        case (idx)
        1:       return 32'h00000073;  // ecall
        2:       return 32'h00100073;  // ebreak
        3:       return 32'h34011073;  // csrrw
        4:       return 32'h0ff0000f;  // fence
        5:       return 32'h0000100f;  // fence.i
        6:       return 32'h4030d093;  // srai x1, x1, 3
        7:       return 32'h4020d0b3;  // sra x1, x1, x2
        8:       return 32'h123450b7;  // lui, rs1 bits nonzero
        9:       return 32'h00000001;
        default: return 32'h00000000;
        endcase
    endfunction

    task automatic report_error(input string what, input logic [31:0] got,
                                input logic [31:0] want);
        errors++;
        $display("Error at time %0t: %s is %h, expected %h", $time, what, got, want);
    endtask

    assign exp_word = (i_rst || model_flushed) ? '0 : (model_stalled ? model_held : i_data);
    assign exp_rs1  = (exp_word[6:0] == {`RV_OP_LUI, 2'b11}) ? '0 : exp_word[19:15];
    assign exp_ctrl = controls_for_word(exp_word);
    assign dut_ctrl = {o_reg_write, o_mem_read, o_mem_write, o_jump, o_branch, o_pc_sel,
                       o_alu_op1_sel, o_alu_op2_sel, o_res_src, o_alu_ctrl};

    always @(posedge i_clk)
    begin
        model_flushed <= i_rst || i_flush;
        model_stalled <= i_stall && !i_rst;
        // word seen when the stall is first sampled stays put
        if (!model_stalled)
            model_held <= exp_word;
        if (i_rst || i_flush)
        begin
            model_pc    <= '0;
            model_pc_p4 <= '0;
        end
        else if (!i_stall)
        begin
            model_pc    <= i_pc;
            model_pc_p4 <= i_pc_p4;
        end
        pc_valid <= 1'b1;
    end

    a_rd: assert property (@(posedge i_clk) o_rd == exp_word[11:7])
        else report_error("o_rd", 32'(o_rd), 32'(exp_word[11:7]));
    a_rs1: assert property (@(posedge i_clk) o_rs1 == exp_rs1)
        else report_error("o_rs1", 32'(o_rs1), 32'(exp_rs1));
    a_rs2: assert property (@(posedge i_clk) o_rs2 == exp_word[24:20])
        else report_error("o_rs2", 32'(o_rs2), 32'(exp_word[24:20]));
    a_funct3: assert property (@(posedge i_clk) o_funct3 == exp_word[14:12])
        else report_error("o_funct3", 32'(o_funct3), 32'(exp_word[14:12]));
    a_imm: assert property (@(posedge i_clk) o_imm == imm_for_word(exp_word))
        else report_error("o_imm", o_imm, imm_for_word(exp_word));
    a_ctrl: assert property (@(posedge i_clk) dut_ctrl == exp_ctrl)
        else report_error("control vector", 32'(dut_ctrl), 32'(exp_ctrl));
    a_inv: assert property (@(posedge i_clk) o_inv_instr == is_invalid(exp_word))
        else report_error("o_inv_instr", 32'(o_inv_instr), 32'(is_invalid(exp_word)));
    a_pc: assert property (@(posedge i_clk) pc_valid |-> o_pc == model_pc)
        else report_error("o_pc", 32'(o_pc), 32'(model_pc));
    a_pc_p4: assert property (@(posedge i_clk) pc_valid |-> o_pc_p4 == model_pc_p4)
        else report_error("o_pc_p4", 32'(o_pc_p4), 32'(model_pc_p4));

    initial
    begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    // watchdog against a stuck stimulus loop
    initial
    begin
        for (int n = 0; n < WATCHDOG_CYCLES; n++)
            @(posedge i_clk);
        $display("Timeout: stimulus did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

    initial
    begin
        errors        = 0;
        stall_left    = 0;
        rng           = 32'd9;
        pc_valid      = 1'b0;
        model_stalled = 1'b0;
        model_flushed = 1'b1;
        model_held    = '0;
        i_rst         = 1'b1;
        i_stall       = 1'b0;
        i_flush       = 1'b0;
        i_data        = '0;
        i_pc          = '0;
        i_pc_p4       = '0;
        for (int n = 0; n < 2; n++)
            @(posedge i_clk);
        i_rst <= 1'b0;
        for (int c = 0; c < NUM_CYCLES; c++)
        begin
            @(posedge i_clk);
            rng = xorshift32(rng);
            a   = rng;
            rng = xorshift32(rng);
            b   = rng;
            rng = xorshift32(rng);
            p   = rng;
            if (c < NUM_DIRECTED)
                i_data <= directed_word(c);
            else
                i_data <= random_word(a, b);
            i_pc    <= p[29:0];
            i_pc_p4 <= p[29:0] + 30'd1;
            // stalls of one to five cycles
            if (stall_left == 0 && c >= NUM_DIRECTED && p[31:29] == 3'd0)
                stall_left = 1 + int'(p[2:0]) % 5;
            i_stall <= (stall_left != 0);
            if (stall_left != 0)
                stall_left--;
            i_flush <= (c >= NUM_DIRECTED && p[15:11] == 5'd0);
            i_rst   <= (c >= 400 && c < 402);
        end
        @(posedge i_clk);
        $display("Decode checks finished with %0d errors", errors);
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

// File: rtl/rv_consts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// opcode groups, bits [6:2]
`define RV_OP_LOAD          5'b00000
`define RV_OP_MISC_MEM      5'b00011
`define RV_OP_ARITH_IMM     5'b00100
`define RV_OP_AUIPC         5'b00101
`define RV_OP_STORE         5'b01000
`define RV_OP_ARITH_REG     5'b01100
`define RV_OP_LUI           5'b01101
`define RV_OP_BRANCH        5'b11000
`define RV_OP_JALR          5'b11001
`define RV_OP_JAL           5'b11011
`define RV_OP_SYSTEM        5'b11100

`define RV_FUNCT7_BASE      7'b0000000
`define RV_FUNCT7_ALT       7'b0100000

// alu operations
`define ALU_CTRL_ADD        4'b0000
`define ALU_CTRL_SUB        4'b0001
`define ALU_CTRL_XOR        4'b0010
`define ALU_CTRL_OR         4'b0011
`define ALU_CTRL_AND        4'b0100
`define ALU_CTRL_SHL        4'b0101
`define ALU_CTRL_SHR        4'b0110

// alu comparisons
`define ALU_CMP_EQ          4'b1000
`define ALU_CMP_NEQ         4'b1001
`define ALU_CMP_LTS         4'b1010
`define ALU_CMP_LTU         4'b1011
`define ALU_CMP_NLTS        4'b1100
`define ALU_CMP_NLTU        4'b1101

`define ALU_SRC_OP1_REG     1'b0
`define ALU_SRC_OP1_PC      1'b1
`define ALU_SRC_OP2_REG     1'b0
`define ALU_SRC_OP2_IMM     1'b1

`define RESULT_SRC_ALU      2'b00
`define RESULT_SRC_MEMORY   2'b01
`define RESULT_SRC_PC_P4    2'b10

`endif

// File: rtl/rv_ctrl_gen.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_ctrl_gen
(
    input  rv_pkg::instr_kind_t i_kind,
    output logic                o_reg_write,
    output logic                o_mem_read,
    output logic                o_mem_write,
    output logic                o_jump,
    output logic                o_branch,
    output logic                o_pc_sel,
    output logic                o_alu_op1_sel,
    output logic                o_alu_op2_sel,
    output rv_pkg::res_src_t    o_res_src,
    output rv_pkg::alu_ctrl_t   o_alu_ctrl
);

    logic w_load;
    logic w_store;
    logic w_arith_imm;
    logic w_arith_reg;
    logic w_branch;
    logic w_jump;

    always_comb
    begin
        w_load      = i_kind inside {rv_pkg::kind_lb, rv_pkg::kind_lh, rv_pkg::kind_lw,
                                     rv_pkg::kind_lbu, rv_pkg::kind_lhu};
        w_store     = i_kind inside {rv_pkg::kind_sb, rv_pkg::kind_sh, rv_pkg::kind_sw};
        w_arith_imm = i_kind inside {rv_pkg::kind_addi, rv_pkg::kind_slti, rv_pkg::kind_sltiu,
                                     rv_pkg::kind_xori, rv_pkg::kind_ori, rv_pkg::kind_andi,
                                     rv_pkg::kind_slli, rv_pkg::kind_srli, rv_pkg::kind_srai};
        w_arith_reg = i_kind inside {rv_pkg::kind_add, rv_pkg::kind_sub, rv_pkg::kind_sll,
                                     rv_pkg::kind_slt, rv_pkg::kind_sltu, rv_pkg::kind_xor,
                                     rv_pkg::kind_srl, rv_pkg::kind_sra, rv_pkg::kind_or,
                                     rv_pkg::kind_and};
        w_branch    = i_kind inside {rv_pkg::kind_beq, rv_pkg::kind_bne, rv_pkg::kind_blt,
                                     rv_pkg::kind_bge, rv_pkg::kind_bltu, rv_pkg::kind_bgeu};
        w_jump      = i_kind inside {rv_pkg::kind_jal, rv_pkg::kind_jalr};

        o_reg_write = w_load || w_arith_imm || w_arith_reg || w_jump
                      || (i_kind inside {rv_pkg::kind_lui, rv_pkg::kind_auipc});
        o_mem_read  = w_load;
        o_mem_write = w_store;
        o_jump      = w_jump;
        o_branch    = w_branch;
        o_pc_sel    = (i_kind == rv_pkg::kind_jalr);

        if (i_kind inside {rv_pkg::kind_auipc, rv_pkg::kind_jal})
            o_alu_op1_sel = `ALU_SRC_OP1_PC;
        else
            o_alu_op1_sel = `ALU_SRC_OP1_REG;

        if (w_jump || w_arith_imm || w_load || w_store
            || (i_kind inside {rv_pkg::kind_auipc, rv_pkg::kind_lui}))
            o_alu_op2_sel = `ALU_SRC_OP2_IMM;
        else
            o_alu_op2_sel = `ALU_SRC_OP2_REG;

        if (w_load)
            o_res_src = `RESULT_SRC_MEMORY;
        else if (w_jump)
            o_res_src = `RESULT_SRC_PC_P4;
        else
            o_res_src = `RESULT_SRC_ALU;

        o_alu_ctrl[4] = (i_kind inside {rv_pkg::kind_sra, rv_pkg::kind_srai});
        case (i_kind)
        rv_pkg::kind_beq:
            o_alu_ctrl[3:0] = `ALU_CMP_EQ;
        rv_pkg::kind_bne:
            o_alu_ctrl[3:0] = `ALU_CMP_NEQ;
        rv_pkg::kind_slt, rv_pkg::kind_slti, rv_pkg::kind_blt:
            o_alu_ctrl[3:0] = `ALU_CMP_LTS;
        rv_pkg::kind_bge:
            o_alu_ctrl[3:0] = `ALU_CMP_NLTS;
        rv_pkg::kind_sltu, rv_pkg::kind_sltiu, rv_pkg::kind_bltu:
            o_alu_ctrl[3:0] = `ALU_CMP_LTU;
        rv_pkg::kind_bgeu:
            o_alu_ctrl[3:0] = `ALU_CMP_NLTU;
        rv_pkg::kind_sub:
            o_alu_ctrl[3:0] = `ALU_CTRL_SUB;
        rv_pkg::kind_xor, rv_pkg::kind_xori:
            o_alu_ctrl[3:0] = `ALU_CTRL_XOR;
        rv_pkg::kind_or, rv_pkg::kind_ori:
            o_alu_ctrl[3:0] = `ALU_CTRL_OR;
        rv_pkg::kind_and, rv_pkg::kind_andi:
            o_alu_ctrl[3:0] = `ALU_CTRL_AND;
        rv_pkg::kind_sll, rv_pkg::kind_slli:
            o_alu_ctrl[3:0] = `ALU_CTRL_SHL;
        rv_pkg::kind_srl, rv_pkg::kind_srli, rv_pkg::kind_sra, rv_pkg::kind_srai:
            o_alu_ctrl[3:0] = `ALU_CTRL_SHR;
        default:
            o_alu_ctrl[3:0] = `ALU_CTRL_ADD;
        endcase

        assert (!(o_mem_read && o_mem_write))
            else $error("memory read and write requested together");
    end

endmodule

// File: rtl/rv_decode.sv
`timescale 1ns/1ps

module rv_decode
(
    input  logic              i_clk,
    input  logic              i_rst,
    input  logic              i_stall,
    input  logic              i_flush,
    input  rv_pkg::instr_t    i_data,
    input  rv_pkg::pc_t       i_pc,
    input  rv_pkg::pc_t       i_pc_p4,
    output rv_pkg::reg_idx_t  o_rs1,
    output rv_pkg::reg_idx_t  o_rs2,
    output rv_pkg::reg_idx_t  o_rd,
    output logic [2:0]        o_funct3,
    output rv_pkg::pc_t       o_pc,
    output rv_pkg::pc_t       o_pc_p4,
    output rv_pkg::imm_t      o_imm,
    output logic              o_reg_write,
    output logic              o_mem_read,
    output logic              o_mem_write,
    output logic              o_jump,
    output logic              o_branch,
    output logic              o_pc_sel,
    output logic              o_alu_op1_sel,
    output logic              o_alu_op2_sel,
    output rv_pkg::res_src_t  o_res_src,
    output rv_pkg::alu_ctrl_t o_alu_ctrl,
    output logic              o_inv_instr
);

    rv_pkg::instr_t      w_instr;
    rv_pkg::instr_kind_t w_kind;
    rv_pkg::imm_fmt_t    w_fmt;

    rv_instr_hold u_hold
    (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_stall (i_stall),
        .i_flush (i_flush),
        .i_data  (i_data),
        .i_pc    (i_pc),
        .i_pc_p4 (i_pc_p4),
        .o_instr (w_instr),
        .o_pc    (o_pc),
        .o_pc_p4 (o_pc_p4)
    );

    rv_instr_class u_class
    (
        .i_instr     (w_instr),
        .o_kind      (w_kind),
        .o_fmt       (w_fmt),
        .o_inv_instr (o_inv_instr)
    );

    rv_imm_gen u_imm
    (
        .i_instr (w_instr),
        .i_fmt   (w_fmt),
        .o_imm   (o_imm)
    );

    rv_ctrl_gen u_ctrl
    (
        .i_kind        (w_kind),
        .o_reg_write   (o_reg_write),
        .o_mem_read    (o_mem_read),
        .o_mem_write   (o_mem_write),
        .o_jump        (o_jump),
        .o_branch      (o_branch),
        .o_pc_sel      (o_pc_sel),
        .o_alu_op1_sel (o_alu_op1_sel),
        .o_alu_op2_sel (o_alu_op2_sel),
        .o_res_src     (o_res_src),
        .o_alu_ctrl    (o_alu_ctrl)
    );

    // lui has no rs1, keep the register file port quiet
    assign o_rs1    = (w_kind == rv_pkg::kind_lui) ? '0 : w_instr[19:15];
    assign o_rs2    = w_instr[24:20];
    assign o_rd     = w_instr[11:7];
    assign o_funct3 = w_instr[14:12];

endmodule

// File: rtl/rv_imm_gen.sv
`timescale 1ns/1ps

module rv_imm_gen
(
    input  rv_pkg::instr_t   i_instr,
    input  rv_pkg::imm_fmt_t i_fmt,
    output rv_pkg::imm_t     o_imm
);

    logic w_sign;

    assign w_sign = i_instr[31];

    always_comb
    begin
        case (i_fmt)
        rv_pkg::fmt_i:
            o_imm = {{21{w_sign}}, i_instr[30:20]};
        rv_pkg::fmt_s:
            o_imm = {{21{w_sign}}, i_instr[30:25], i_instr[11:7]};
        // b and j offsets are in half words
        rv_pkg::fmt_b:
            o_imm = {{20{w_sign}}, i_instr[7], i_instr[30:25], i_instr[11:8], 1'b0};
        rv_pkg::fmt_u:
            o_imm = {i_instr[31:12], 12'b0};
        rv_pkg::fmt_j:
            o_imm = {{12{w_sign}}, i_instr[19:12], i_instr[20], i_instr[30:21], 1'b0};
        default:
            o_imm = '0;
        endcase
    end

endmodule

// File: rtl/rv_instr_class.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_instr_class
(
    input  rv_pkg::instr_t      i_instr,
    output rv_pkg::instr_kind_t o_kind,
    output rv_pkg::imm_fmt_t    o_fmt,
    output logic                o_inv_instr
);

    logic [6:0] w_op;
    logic [2:0] w_funct3;
    logic [6:0] w_funct7;
    logic       w_valid;

    assign w_op     = i_instr[6:0];
    assign w_funct3 = i_instr[14:12];
    assign w_funct7 = i_instr[31:25];

    always_comb
    begin
        w_valid = 1'b1;
        o_kind  = rv_pkg::kind_invalid;
        if (i_instr == '0)
            o_kind = rv_pkg::kind_none;
        else if (w_op[1:0] != 2'b11)
            w_valid = 1'b0;
        else
        begin
            case (w_op[6:2])
            `RV_OP_LOAD:
                case (w_funct3)
                3'b000:  o_kind = rv_pkg::kind_lb;
                3'b001:  o_kind = rv_pkg::kind_lh;
                3'b010:  o_kind = rv_pkg::kind_lw;
                3'b100:  o_kind = rv_pkg::kind_lbu;
                3'b101:  o_kind = rv_pkg::kind_lhu;
                default: w_valid = 1'b0;
                endcase
            `RV_OP_MISC_MEM:
                case (w_funct3)
                3'b000:  o_kind = rv_pkg::kind_fence;
                3'b001:  o_kind = rv_pkg::kind_fence_i;
                default: w_valid = 1'b0;
                endcase
            `RV_OP_ARITH_IMM:
                case (w_funct3)
                3'b000:  o_kind = rv_pkg::kind_addi;
                3'b010:  o_kind = rv_pkg::kind_slti;
                3'b011:  o_kind = rv_pkg::kind_sltiu;
                3'b100:  o_kind = rv_pkg::kind_xori;
                3'b110:  o_kind = rv_pkg::kind_ori;
                3'b111:  o_kind = rv_pkg::kind_andi;
                3'b001:
                    if (w_funct7 == `RV_FUNCT7_BASE)
                        o_kind = rv_pkg::kind_slli;
                    else
                        w_valid = 1'b0;
                default:
                    if (w_funct7 == `RV_FUNCT7_BASE)
                        o_kind = rv_pkg::kind_srli;
                    else if (w_funct7 == `RV_FUNCT7_ALT)
                        o_kind = rv_pkg::kind_srai;
                    else
                        w_valid = 1'b0;
                endcase
            `RV_OP_AUIPC:
                o_kind = rv_pkg::kind_auipc;
            `RV_OP_STORE:
                case (w_funct3)
                3'b000:  o_kind = rv_pkg::kind_sb;
                3'b001:  o_kind = rv_pkg::kind_sh;
                3'b010:  o_kind = rv_pkg::kind_sw;
                default: w_valid = 1'b0;
                endcase
            `RV_OP_ARITH_REG:
                case ({w_funct7, w_funct3})
                {`RV_FUNCT7_BASE, 3'b000}: o_kind = rv_pkg::kind_add;
                {`RV_FUNCT7_ALT,  3'b000}: o_kind = rv_pkg::kind_sub;
                {`RV_FUNCT7_BASE, 3'b001}: o_kind = rv_pkg::kind_sll;
                {`RV_FUNCT7_BASE, 3'b010}: o_kind = rv_pkg::kind_slt;
                {`RV_FUNCT7_BASE, 3'b011}: o_kind = rv_pkg::kind_sltu;
                {`RV_FUNCT7_BASE, 3'b100}: o_kind = rv_pkg::kind_xor;
                {`RV_FUNCT7_BASE, 3'b101}: o_kind = rv_pkg::kind_srl;
                {`RV_FUNCT7_ALT,  3'b101}: o_kind = rv_pkg::kind_sra;
                {`RV_FUNCT7_BASE, 3'b110}: o_kind = rv_pkg::kind_or;
                {`RV_FUNCT7_BASE, 3'b111}: o_kind = rv_pkg::kind_and;
                default:                   w_valid = 1'b0;
                endcase
            `RV_OP_LUI:
                o_kind = rv_pkg::kind_lui;
            `RV_OP_BRANCH:
                case (w_funct3)
                3'b000:  o_kind = rv_pkg::kind_beq;
                3'b001:  o_kind = rv_pkg::kind_bne;
                3'b100:  o_kind = rv_pkg::kind_blt;
                3'b101:  o_kind = rv_pkg::kind_bge;
                3'b110:  o_kind = rv_pkg::kind_bltu;
                3'b111:  o_kind = rv_pkg::kind_bgeu;
                default: w_valid = 1'b0;
                endcase
            `RV_OP_JALR:
                if (w_funct3 == 3'b000)
                    o_kind = rv_pkg::kind_jalr;
                else
                    w_valid = 1'b0;
            `RV_OP_JAL:
                o_kind = rv_pkg::kind_jal;
            // ecall, ebreak and csr words, no Zicsr here
            `RV_OP_SYSTEM:
                w_valid = 1'b0;
            default:
                w_valid = 1'b0;
            endcase
        end
        assert (w_valid == (o_kind != rv_pkg::kind_invalid))
            else $error("invalid flag disagrees with instruction kind");
    end

    assign o_inv_instr = !w_valid;

    always_comb
    begin
        case (o_kind)
        rv_pkg::kind_jal:
            o_fmt = rv_pkg::fmt_j;
        rv_pkg::kind_lui, rv_pkg::kind_auipc:
            o_fmt = rv_pkg::fmt_u;
        rv_pkg::kind_jalr, rv_pkg::kind_lb, rv_pkg::kind_lh, rv_pkg::kind_lw,
        rv_pkg::kind_lbu, rv_pkg::kind_lhu, rv_pkg::kind_addi, rv_pkg::kind_slti,
        rv_pkg::kind_sltiu, rv_pkg::kind_xori, rv_pkg::kind_ori, rv_pkg::kind_andi,
        rv_pkg::kind_slli, rv_pkg::kind_srli, rv_pkg::kind_srai:
            o_fmt = rv_pkg::fmt_i;
        rv_pkg::kind_beq, rv_pkg::kind_bne, rv_pkg::kind_blt,
        rv_pkg::kind_bge, rv_pkg::kind_bltu, rv_pkg::kind_bgeu:
            o_fmt = rv_pkg::fmt_b;
        rv_pkg::kind_sb, rv_pkg::kind_sh, rv_pkg::kind_sw:
            o_fmt = rv_pkg::fmt_s;
        default:
            o_fmt = rv_pkg::fmt_none;
        endcase
    end

endmodule

// File: rtl/rv_instr_hold.sv
`timescale 1ns/1ps

module rv_instr_hold
(
    input  logic          i_clk,
    input  logic          i_rst,
    input  logic          i_stall,
    input  logic          i_flush,
    input  rv_pkg::instr_t i_data,
    input  rv_pkg::pc_t    i_pc,
    input  rv_pkg::pc_t    i_pc_p4,
    output rv_pkg::instr_t o_instr,
    output rv_pkg::pc_t    o_pc,
    output rv_pkg::pc_t    o_pc_p4
);

    rv_pkg::instr_t r_instr;
    rv_pkg::instr_t r_instr_buf;
    rv_pkg::instr_t w_instr;
    logic [1:0]     r_stall;
    logic           r_flush;

    // reset is treated as a flush so the word after it is still zero
    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            r_stall <= '0;
            r_flush <= 1'b1;
        end
        else
        begin
            r_stall <= {r_stall[0] & i_stall, i_stall};
            r_flush <= i_flush;
        end
    end

    // last decoded word, frozen once the stall is two cycles old
    always_ff @(posedge i_clk)
    begin
        if (!(&r_stall))
        begin
            r_instr     <= w_instr;
            r_instr_buf <= r_instr;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_rst || i_flush)
        begin
            o_pc    <= '0;
            o_pc_p4 <= '0;
        end
        else if (!i_stall)
        begin
            o_pc    <= i_pc;
            o_pc_p4 <= i_pc_p4;
        end
    end

    always_comb
    begin
        if (i_rst || r_flush)
            w_instr = '0;
        else if (r_stall[0])
            w_instr = r_stall[1] ? r_instr_buf : r_instr;
        else
            w_instr = i_data;
    end

    assign o_instr = w_instr;

    a_flush_clears_word: assert property (@(posedge i_clk) i_flush |=> (o_instr == '0))
        else $error("decode word not cleared after flush");

endmodule

// File: rtl/rv_pkg.sv
package rv_pkg;

    typedef logic [31:0] instr_t;
    typedef logic [31:2] pc_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [31:0] imm_t;
    // bit 4 selects arithmetic shift
    typedef logic [4:0]  alu_ctrl_t;
    typedef logic [1:0]  res_src_t;

    typedef enum logic [5:0]
    {
        kind_none,
        kind_invalid,
        kind_lb, kind_lh, kind_lw, kind_lbu, kind_lhu,
        kind_addi, kind_slti, kind_sltiu, kind_xori, kind_ori, kind_andi,
        kind_slli, kind_srli, kind_srai,
        kind_auipc,
        kind_sb, kind_sh, kind_sw,
        kind_add, kind_sub, kind_sll, kind_slt, kind_sltu,
        kind_xor, kind_srl, kind_sra, kind_or, kind_and,
        kind_lui,
        kind_beq, kind_bne, kind_blt, kind_bge, kind_bltu, kind_bgeu,
        kind_jalr,
        kind_jal,
        kind_fence,
        kind_fence_i
    } instr_kind_t;

    typedef enum logic [2:0]
    {
        fmt_none,
        fmt_i,
        fmt_s,
        fmt_b,
        fmt_u,
        fmt_j
    } imm_fmt_t;

endpackage

// File: run_sim.sh
#!/bin/sh
# build and run the decode testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f rv_decode.f --top-module tb_rv_decode -Mdir obj_dir -o sim_rv_decode
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_rv_decode)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^Simulation PASSED$"; then
    exit 0
fi
exit 1

// File: rv_decode.f
+incdir+rtl
rtl/rv_pkg.sv
rtl/rv_instr_hold.sv
rtl/rv_instr_class.sv
rtl/rv_imm_gen.sv
rtl/rv_ctrl_gen.sv
rtl/rv_decode.sv
bench/tb_rv_decode.sv
